/* logic/rf_params.svh */
////////////////////////////////////////////////////////////////////////////
// Width and size macros for the register file with byte-parity integrity.
// Included by the package and by any module that sizes its own logic.
////////////////////////////////////////////////////////////////////////////

`ifndef RF_PARAMS_SVH
`define RF_PARAMS_SVH

// Data word and its integrity code with one parity bit per byte
`define RF_DATA_W   32
`define RF_INTG_W   4

// Register addressing
`define RF_ADDR_W   5
`define RF_NUM_REGS 32

`endif

/* logic/rf_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types and the integrity function of the register file.
// Modules refer to these by scoped name, e.g. rf_pkg::rf_word_t.
////////////////////////////////////////////////////////////////////////////

`include "rf_params.svh"

package rf_pkg;

  // Plain data word as seen on the ports
  typedef logic [`RF_DATA_W-1:0] rf_data_t;

  // One even-parity bit per byte of data
  typedef logic [`RF_INTG_W-1:0] rf_intg_t;

  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

  // Stored word with the code in the top bits and the data below
  typedef logic [`RF_INTG_W+`RF_DATA_W-1:0] rf_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Integrity code
  ////////////////////////////////////////////////////////////////////////////

  // Bit k is the XOR of byte k, so an all-zero word has an all-zero code
  function automatic rf_intg_t calc_intg(rf_data_t data);
    rf_intg_t intg;
    intg = '0;
    for (int k = 0; k < `RF_INTG_W; k++) begin
      intg[k] = ^data[8*k +: 8];
    end
    return intg;
  endfunction

endpackage

/* logic/rf_wb_stage.sv */
////////////////////////////////////////////////////////////////////////////
// Writeback stage of the register file. Registers one write per strobe
// with its bus integrity code and flags a bad code on the bus alert.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rf_wb_stage (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Write request from the core
  input  logic              we_i,
  input  rf_pkg::rf_addr_t  waddr_i,
  input  rf_pkg::rf_data_t  wdata_i,
  input  rf_pkg::rf_intg_t  wdata_intg_i,

  // Towards the register file
  output logic              wb_we_o,
  output rf_pkg::rf_addr_t  wb_addr_o,
  output rf_pkg::rf_word_t  wb_word_o,

  output logic              alert_major_bus_o
);

  logic             intg_err;
  logic             wb_we_q;
  logic             bus_alert_q;
  rf_pkg::rf_addr_t wb_addr_q;
  rf_pkg::rf_word_t wb_word_q;

  ////////////////////////////////////////////////////////////////////////////
  // Integrity check
  ////////////////////////////////////////////////////////////////////////////

  // Checked for every write, register 0 included
  assign intg_err = we_i & (wdata_intg_i != rf_pkg::calc_intg(wdata_i));

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_we_q     <= 1'b0;
      bus_alert_q <= 1'b0;
    end else begin
      wb_we_q     <= we_i;
      bus_alert_q <= intg_err;
    end
  end

  // Payload only moves with a strobe; the code is kept as given
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      wb_addr_q <= waddr_i;
      wb_word_q <= {wdata_intg_i, wdata_i};
    end
  end

  assign wb_we_o           = wb_we_q;
  assign wb_addr_o         = wb_addr_q;
  assign wb_word_o         = wb_word_q;
  assign alert_major_bus_o = bus_alert_q;

endmodule

/* logic/rf_regfile_ff.sv */
////////////////////////////////////////////////////////////////////////////
// Flop-based register file, one write port and two combinational read
// ports. Register 0 is hardwired to the all-zero word.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "rf_params.svh"

module rf_regfile_ff (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Write port
  input  logic              we_i,
  input  rf_pkg::rf_addr_t  waddr_i,
  input  rf_pkg::rf_word_t  wword_i,

  // Read ports
  input  rf_pkg::rf_addr_t  raddr_a_i,
  input  rf_pkg::rf_addr_t  raddr_b_i,
  output rf_pkg::rf_word_t  rword_a_o,
  output rf_pkg::rf_word_t  rword_b_o
);

  rf_pkg::rf_word_t                 mem [`RF_NUM_REGS];
  logic [`RF_NUM_REGS-1:0]          we_dec;

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    we_dec = '0;
    for (int i = 1; i < `RF_NUM_REGS; i++) begin
      we_dec[i] = we_i & (waddr_i == rf_pkg::rf_addr_t'(i));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Zero data with a zero code is a valid word, so reset leaves
  // every register clean
  for (genvar i = 1; i < `RF_NUM_REGS; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        mem[i] <= '0;
      end else if (we_dec[i]) begin
        mem[i] <= wword_i;
      end
    end
  end

  // Register 0 ignores writes
  assign mem[0] = '0;

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////

  assign rword_a_o = mem[raddr_a_i];
  assign rword_b_o = mem[raddr_b_i];

endmodule

/* logic/rf_read_stage.sv */
////////////////////////////////////////////////////////////////////////////
// Read stage of the register file. Registers both read ports on a strobe,
// strips the codes and raises the internal alert on a bad stored word.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "rf_params.svh"

module rf_read_stage (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              re_i,

  // Words returned by the register file
  input  rf_pkg::rf_word_t  rword_a_i,
  input  rf_pkg::rf_word_t  rword_b_i,

  output logic              rvalid_o,
  output rf_pkg::rf_data_t  rdata_a_o,
  output rf_pkg::rf_data_t  rdata_b_o,
  output logic              alert_major_internal_o
);

  rf_pkg::rf_data_t data_a;
  rf_pkg::rf_data_t data_b;
  rf_pkg::rf_intg_t intg_a;
  rf_pkg::rf_intg_t intg_b;
  logic             intg_err_a;
  logic             intg_err_b;

  logic             rvalid_q;
  logic             int_alert_q;
  rf_pkg::rf_data_t rdata_a_q;
  rf_pkg::rf_data_t rdata_b_q;

  ////////////////////////////////////////////////////////////////////////////
  // Split and check
  ////////////////////////////////////////////////////////////////////////////

  assign data_a = rword_a_i[`RF_DATA_W-1:0];
  assign data_b = rword_b_i[`RF_DATA_W-1:0];
  assign intg_a = rword_a_i[`RF_DATA_W +: `RF_INTG_W];
  assign intg_b = rword_b_i[`RF_DATA_W +: `RF_INTG_W];

  // Stored code is recomputed from the stored data
  assign intg_err_a = (intg_a != rf_pkg::calc_intg(data_a));
  assign intg_err_b = (intg_b != rf_pkg::calc_intg(data_b));

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q    <= 1'b0;
      int_alert_q <= 1'b0;
    end else begin
      rvalid_q    <= re_i;
      // Only a word that is actually read can raise the alert
      int_alert_q <= re_i & (intg_err_a | intg_err_b);
    end
  end

  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_a_q <= data_a;
      rdata_b_q <= data_b;
    end
  end

  assign rvalid_o               = rvalid_q;
  assign rdata_a_o              = rdata_a_q;
  assign rdata_b_o              = rdata_b_q;
  assign alert_major_internal_o = int_alert_q;

endmodule

/* logic/rf_top.sv */
////////////////////////////////////////////////////////////////////////////
// Top of the register file block: writeback stage, flop register file
// and read stage. A write is visible to reads two edges after its strobe.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rf_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Write port with bus integrity
  input  logic              we_i,
  input  rf_pkg::rf_addr_t  waddr_i,
  input  rf_pkg::rf_data_t  wdata_i,
  input  rf_pkg::rf_intg_t  wdata_intg_i,

  // Dual read port
  input  logic              re_i,
  input  rf_pkg::rf_addr_t  raddr_a_i,
  input  rf_pkg::rf_addr_t  raddr_b_i,
  output logic              rvalid_o,
  output rf_pkg::rf_data_t  rdata_a_o,
  output rf_pkg::rf_data_t  rdata_b_o,

  // Alerts
  output logic              alert_major_bus_o,
  output logic              alert_major_internal_o
);

  // Writeback to register file
  logic             wb_we;
  rf_pkg::rf_addr_t wb_addr;
  rf_pkg::rf_word_t wb_word;

  // Register file to read stage
  rf_pkg::rf_word_t rword_a;
  rf_pkg::rf_word_t rword_b;

  ////////////////////////////////////////////////////////////////////////////
  // Writeback stage
  ////////////////////////////////////////////////////////////////////////////

  rf_wb_stage u_rf_wb_stage (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .we_i             (we_i),
    .waddr_i          (waddr_i),
    .wdata_i          (wdata_i),
    .wdata_intg_i     (wdata_intg_i),
    .wb_we_o          (wb_we),
    .wb_addr_o        (wb_addr),
    .wb_word_o        (wb_word),
    .alert_major_bus_o(alert_major_bus_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  rf_regfile_ff u_rf_regfile_ff (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .we_i     (wb_we),
    .waddr_i  (wb_addr),
    .wword_i  (wb_word),
    .raddr_a_i(raddr_a_i),
    .raddr_b_i(raddr_b_i),
    .rword_a_o(rword_a),
    .rword_b_o(rword_b)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Read stage
  ////////////////////////////////////////////////////////////////////////////

  rf_read_stage u_rf_read_stage (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .re_i                  (re_i),
    .rword_a_i             (rword_a),
    .rword_b_i             (rword_b),
    .rvalid_o              (rvalid_o),
    .rdata_a_o             (rdata_a_o),
    .rdata_b_o             (rdata_b_o),
    .alert_major_internal_o(alert_major_internal_o)
  );

endmodule

/* verification/rf_tb_checks.svh */
////////////////////////////////////////////////////////////////////////////
// Reference model of the register file and the typed compare tasks.
// Included inside the testbench module, after the error counters.
////////////////////////////////////////////////////////////////////////////

`ifndef RF_TB_CHECKS_SVH
`define RF_TB_CHECKS_SVH

// Expected contents with the code in the upper bits as the DUT stores them
rf_pkg::rf_word_t model_mem [`RF_NUM_REGS];

// Write driven in the previous cycle and not yet visible to reads
logic             pend_we;
rf_pkg::rf_addr_t pend_addr;
rf_pkg::rf_word_t pend_word;

// Even parity of each byte
function automatic rf_pkg::rf_intg_t ref_intg(rf_pkg::rf_data_t data);
  rf_pkg::rf_intg_t code;
  code = '0;
  for (int b = 0; b < `RF_INTG_W; b++) begin
    for (int i = 0; i < 8; i++) begin
      code[b] = code[b] ^ data[8*b + i];
    end
  end
  return code;
endfunction

function automatic rf_pkg::rf_word_t model_read(rf_pkg::rf_addr_t addr);
  if (addr == '0) begin
    return '0;
  end
  return model_mem[addr];
endfunction

function automatic logic word_bad(rf_pkg::rf_word_t word);
  return word[`RF_DATA_W +: `RF_INTG_W] != ref_intg(word[`RF_DATA_W-1:0]);
endfunction

task automatic model_reset();
  for (int i = 0; i < `RF_NUM_REGS; i++) begin
    model_mem[i] = '0;
  end
  pend_we   = 1'b0;
  pend_addr = '0;
  pend_word = '0;
endtask

// Commit last cycle's write, then hold the current one back a cycle
task automatic model_step(logic we, rf_pkg::rf_addr_t addr, rf_pkg::rf_word_t word);
  if (pend_we && pend_addr != '0) begin
    model_mem[pend_addr] = pend_word;
  end
  pend_we   = we;
  pend_addr = addr;
  pend_word = word;
endtask

task automatic check_data(string name, rf_pkg::rf_data_t exp, rf_pkg::rf_data_t act);
  if (act !== exp) begin
    data_errs++;
    $display("ERROR [%0t] %s: expected %h, actual %h", $time, name, exp, act);
  end
endtask

task automatic check_flag(string name, logic exp, logic act);
  if (act !== exp) begin
    flag_errs++;
    $display("ERROR [%0t] %s: expected %b, actual %b", $time, name, exp, act);
  end
endtask

`endif

/* verification/rf_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the register file top. Drives writes and reads on the
// falling edge and checks data, rvalid and both alerts one cycle later.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "rf_params.svh"

module rf_tb;

  localparam int SEED          = 32'h5d10bd77;
  localparam int RESET_CYCLES  = 5;
  localparam int RESET_READS   = `RF_NUM_REGS;
  localparam int RANDOM_WRITES = 200;
  localparam int ZERO_WRITES   = 4;
  localparam int BAD_WRITES    = 8;
  localparam int MIX_CYCLES    = 300;

  // Test lengths including their idle tails
  localparam int STIM_CYCLES = RESET_CYCLES + (RESET_READS + 2) + (RANDOM_WRITES + 4) +
                               (ZERO_WRITES + 5) + (3 * BAD_WRITES + 3) + (MIX_CYCLES + 3);
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  logic             clk_i;
  logic             rst_ni;
  logic             we_i;
  rf_pkg::rf_addr_t waddr_i;
  rf_pkg::rf_data_t wdata_i;
  rf_pkg::rf_intg_t wdata_intg_i;
  logic             re_i;
  rf_pkg::rf_addr_t raddr_a_i;
  rf_pkg::rf_addr_t raddr_b_i;
  logic             rvalid_o;
  rf_pkg::rf_data_t rdata_a_o;
  rf_pkg::rf_data_t rdata_b_o;
  logic             alert_major_bus_o;
  logic             alert_major_internal_o;

  int cycle = 0;
  int cur_test = 0;
  int data_errs = 0;
  int flag_errs = 0;
  int proto_errs = 0;

  // One entry per driven cycle that is checked on the next falling edge
  int               due_q[$];
  int               test_q[$];
  logic             valid_q[$];
  logic             bus_q[$];
  logic             int_q[$];
  rf_pkg::rf_data_t data_a_q[$];
  rf_pkg::rf_data_t data_b_q[$];

  rf_pkg::rf_addr_t wr_hist [RANDOM_WRITES];

  `include "rf_tb_checks.svh"

  rf_top i_rf_top (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .we_i                  (we_i),
    .waddr_i               (waddr_i),
    .wdata_i               (wdata_i),
    .wdata_intg_i          (wdata_intg_i),
    .re_i                  (re_i),
    .raddr_a_i             (raddr_a_i),
    .raddr_b_i             (raddr_b_i),
    .rvalid_o              (rvalid_o),
    .rdata_a_o             (rdata_a_o),
    .rdata_b_o             (rdata_b_o),
    .alert_major_bus_o     (alert_major_bus_o),
    .alert_major_internal_o(alert_major_internal_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic string test_label(int id);
    case (id)
      0:       return "reset_state";
      1:       return "random_rw";
      2:       return "reg_zero";
      3:       return "bad_code";
      default: return "back_to_back";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive(logic we, rf_pkg::rf_addr_t waddr, rf_pkg::rf_data_t wdata,
                       logic bad, logic re, rf_pkg::rf_addr_t ra, rf_pkg::rf_addr_t rb);
    rf_pkg::rf_intg_t code;
    rf_pkg::rf_word_t word_a;
    rf_pkg::rf_word_t word_b;
    @(negedge clk_i);
    code = ref_intg(wdata);
    // Flip one parity bit for a corrupt write
    if (bad) begin
      code = code ^ (rf_pkg::rf_intg_t'(1) << ($urandom % `RF_INTG_W));
    end
    we_i         = we;
    waddr_i      = waddr;
    wdata_i      = wdata;
    wdata_intg_i = code;
    re_i         = re;
    raddr_a_i    = ra;
    raddr_b_i    = rb;
    word_a = model_read(ra);
    word_b = model_read(rb);
    due_q.push_back(cycle + 1);
    test_q.push_back(cur_test);
    valid_q.push_back(re);
    bus_q.push_back(we && bad);
    int_q.push_back(re && (word_bad(word_a) || word_bad(word_b)));
    data_a_q.push_back(word_a[`RF_DATA_W-1:0]);
    data_b_q.push_back(word_b[`RF_DATA_W-1:0]);
    model_step(we, waddr, {code, wdata});
  endtask

  task automatic idle(int n);
    repeat (n) drive(1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare_proc
    string name;
    if (due_q.size() > 0 && due_q[0] == cycle) begin
      name = test_label(test_q[0]);
      if (valid_q[0] && rvalid_o !== 1'b1) begin
        proto_errs++;
        $display("[%0t] %s: read was issued but rvalid did not rise", $time, name);
      end else if (!valid_q[0] && rvalid_o !== 1'b0) begin
        proto_errs++;
        $display("[%0t] %s: rvalid rose without a read", $time, name);
      end else if (valid_q[0]) begin
        check_data({name, " port a"}, data_a_q[0], rdata_a_o);
        check_data({name, " port b"}, data_b_q[0], rdata_b_o);
      end
      check_flag({name, " bus alert"}, bus_q[0], alert_major_bus_o);
      check_flag({name, " internal alert"}, int_q[0], alert_major_internal_o);
      void'(due_q.pop_front());
      void'(test_q.pop_front());
      void'(valid_q.pop_front());
      void'(bus_q.pop_front());
      void'(int_q.pop_front());
      void'(data_a_q.pop_front());
      void'(data_b_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rf_pkg::rf_addr_t addr;
    rf_pkg::rf_addr_t last_waddr;
    void'($urandom(SEED));
    rst_ni       = 1'b0;
    we_i         = 1'b0;
    waddr_i      = '0;
    wdata_i      = '0;
    wdata_intg_i = '0;
    re_i         = 1'b0;
    raddr_a_i    = '0;
    raddr_b_i    = '0;
    last_waddr   = '0;
    model_reset();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    cur_test = 0;
    for (int i = 0; i < RESET_READS; i++) begin
      drive(1'b0, '0, '0, 1'b0, 1'b1, rf_pkg::rf_addr_t'(i),
            rf_pkg::rf_addr_t'(RESET_READS - 1 - i));
    end
    idle(2);

    // Each address is read back exactly two cycles after its write
    cur_test = 1;
    for (int i = 0; i < RANDOM_WRITES + 2; i++) begin
      addr = rf_pkg::rf_addr_t'(1 + $urandom % (`RF_NUM_REGS - 1));
      if (i < RANDOM_WRITES) begin
        wr_hist[i] = addr;
      end
      drive(i < RANDOM_WRITES, addr, $urandom, 1'b0, i >= 2,
            (i >= 2) ? wr_hist[i-2] : '0, (i >= 2) ? wr_hist[i-2] : '0);
    end
    idle(2);

    cur_test = 2;
    for (int i = 0; i < ZERO_WRITES; i++) begin
      drive(1'b1, '0, $urandom, 1'b0, 1'b1, '0, '0);
    end
    idle(2);
    drive(1'b0, '0, '0, 1'b0, 1'b1, '0, '0);
    idle(2);

    cur_test = 3;
    for (int i = 0; i < BAD_WRITES; i++) begin
      addr = rf_pkg::rf_addr_t'(1 + $urandom % (`RF_NUM_REGS - 1));
      drive(1'b1, addr, $urandom, 1'b1, 1'b0, '0, '0);
      idle(1);
      drive(1'b0, '0, '0, 1'b0, 1'b1, addr, addr);
    end
    // Bus check applies to register 0 too
    drive(1'b1, '0, $urandom, 1'b1, 1'b0, '0, '0);
    idle(2);

    // Port a often reads the register written the cycle before
    cur_test = 4;
    for (int i = 0; i < MIX_CYCLES; i++) begin
      addr = rf_pkg::rf_addr_t'($urandom % `RF_NUM_REGS);
      drive(($urandom % 2) == 1, addr, $urandom, ($urandom % 16) == 0, ($urandom % 2) == 1,
            (($urandom % 2) == 1) ? last_waddr : rf_pkg::rf_addr_t'($urandom % `RF_NUM_REGS),
            rf_pkg::rf_addr_t'($urandom % `RF_NUM_REGS));
      last_waddr = addr;
    end
    idle(3);

    repeat (2) @(negedge clk_i);
    if (due_q.size() != 0) begin
      proto_errs++;
      $display("%0d expected responses were never checked", due_q.size());
    end
    $display("Errors: data %0d, flags %0d, protocol %0d", data_errs, flag_errs, proto_errs);
    if (data_errs + flag_errs + proto_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+logic
+incdir+verification
logic/rf_pkg.sv
logic/rf_wb_stage.sv
logic/rf_regfile_ff.sv
logic/rf_read_stage.sv
logic/rf_top.sv
verification/rf_tb.sv
